// File: design/tlx_cmd_pkg.sv
// shared widths, length codes and credit limits for the command issue stage
// imported by the RTL modules and the testbench that need them

package tlx_cmd_pkg;

   // ---------------------------------------------------------------------
   // command field widths
   // ---------------------------------------------------------------------
   localparam int opcode_w = 8;
   localparam int ea_w     = 68;
   localparam int afutag_w = 16;
   localparam int dl_w     = 2;
   localparam int pl_w     = 3;

   // packed order, lsb first: opcode, ea, afutag, dl, pl
   localparam int cmd_info_w = opcode_w + ea_w + afutag_w + dl_w + pl_w;

   // data length codes
   localparam logic [dl_w-1:0] dl_64b  = 2'd1;
   localparam logic [dl_w-1:0] dl_128b = 2'd2;

   // ---------------------------------------------------------------------
   // credits
   // ---------------------------------------------------------------------
   localparam int cmd_credit_w  = 4;
   localparam int data_credit_w = 6;

   // enough data credit for both beats of a 128B write
   localparam int min_data_credit = 2;

   // issue sequencing
   typedef enum logic {
      st_cmd,
      st_odd_data
   } issue_state_e;

endpackage

// File: design/cmd_fifo.sv
// single clock show-ahead FIFO for one command channel
// head is valid whenever empty is low; half_ready drives the sender's ready level

module cmd_fifo #(
   parameter int data_w = 97,
   parameter int addr_w = 4
) (
   input  logic              clk_tlx,
   input  logic              rst_n,
   input  logic              push,
   input  logic [data_w-1:0] push_data,
   input  logic              pop,
   output logic [data_w-1:0] head,
   output logic              empty,
   output logic              half_ready,
   output logic              overflow
);

   localparam logic [addr_w:0] depth = (addr_w + 1)'(1 << addr_w);

   logic [data_w-1:0] mem [0:(1 << addr_w)-1];
   logic [addr_w-1:0] wr_ptr;
   logic [addr_w-1:0] rd_ptr;
   logic [addr_w:0]   count;
   logic              full;
   logic              do_push;
   logic              do_pop;

   assign full       = (count == depth);
   assign empty      = (count == '0);
   assign half_ready = (count < (depth >> 1));
   assign do_push    = push && !full;
   assign do_pop     = pop && !empty;
   assign head       = mem[rd_ptr];

   always_ff @(posedge clk_tlx)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // a strobe into a full queue is lost, keep the fault until reset
         if (push && full)
            overflow <= 1'b1;
      end
   end

endmodule

// File: design/credit_counter.sv
// command and data credit tracking toward the transaction layer
// loads the initial credit once after reset, then follows returns and spends

module credit_counter
   import tlx_cmd_pkg::*;
(
   input  logic                     clk_tlx,
   input  logic                     rst_n,
   input  logic [cmd_credit_w-1:0]  cmd_initial_credit,
   input  logic [data_credit_w-1:0] data_initial_credit,
   input  logic                     cmd_credit,
   input  logic                     data_credit,
   input  logic                     cmd_spent,
   input  logic                     data_spent,
   output logic                     issue_ok
);

   logic                     loaded;
   logic [cmd_credit_w-1:0]  cmd_cnt;
   logic [data_credit_w-1:0] data_cnt;

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         loaded   <= 1'b0;
         cmd_cnt  <= '0;
         data_cnt <= '0;
      end
      else if (!loaded)
      begin
         loaded   <= 1'b1;
         cmd_cnt  <= cmd_initial_credit;
         data_cnt <= data_initial_credit;
      end
      else
      begin
         // return and spend in the same cycle cancel out
         case ({cmd_credit, cmd_spent})
            2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
            2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
            default: cmd_cnt <= cmd_cnt;
         endcase
         case ({data_credit, data_spent})
            2'b10:   data_cnt <= data_cnt + 1'b1;
            2'b01:   data_cnt <= data_cnt - 1'b1;
            default: data_cnt <= data_cnt;
         endcase
      end
   end

   // one command slot and room for a full 128B write
   assign issue_ok = (cmd_cnt != '0) &&
                     (data_cnt >= data_credit_w'(min_data_credit));

endmodule

// File: design/cmd_issue_fsm.sv
// picks read or write for each issue slot and sequences the write data beats
// the pops, valids and mux selects all come out of this block combinationally

module cmd_issue_fsm
   import tlx_cmd_pkg::*;
(
   input  logic            clk_tlx,
   input  logic            rst_n,
   input  logic            wr_empty,
   input  logic            rd_empty,
   input  logic [dl_w-1:0] wr_dl,
   input  logic            issue_ok,
   output logic            wr_pop,
   output logic            rd_pop,
   output logic            cmd_valid,
   output logic            cdata_valid,
   output logic            sel_write,
   output logic            sel_high
);

   issue_state_e state;
   logic         last_write;
   logic         can_issue;
   logic         pick_write;

   // ---------------------------------------------------------------------
   // arbitration
   // ---------------------------------------------------------------------

   // write wins when it is alone or when read was served last
   assign pick_write = !wr_empty && (rd_empty || !last_write);

   // no command slot while the high beat is on the bus
   assign can_issue = (state == st_cmd) && issue_ok && !(wr_empty && rd_empty);

   assign wr_pop    = can_issue && pick_write;
   assign rd_pop    = can_issue && !pick_write;
   assign cmd_valid = can_issue;
   assign sel_write = pick_write;

   // ---------------------------------------------------------------------
   // data beats
   // ---------------------------------------------------------------------

   // low beat rides with the write command, high beat follows alone
   assign sel_high    = (state == st_odd_data);
   assign cdata_valid = wr_pop || sel_high;

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= st_cmd;
         last_write <= 1'b0;
      end
      else
      begin
         if (can_issue)
            last_write <= pick_write;
         case (state)
            st_cmd:
            begin
               if (wr_pop && (wr_dl == dl_128b))
                  state <= st_odd_data;
            end
            default:
            begin
               state <= st_cmd;
            end
         endcase
      end
   end

endmodule

// File: design/tlx_cmd_issue.sv
// command issue stage between the accelerator read/write channels and the TLX port
// queues each channel, alternates between them and gates issue on TLX credits

module tlx_cmd_issue
   import tlx_cmd_pkg::*;
#(
   parameter int half_data_w = 512,
   parameter int fifo_addr_w = 4
) (
   input  logic                     clk_tlx,
   input  logic                     rst_n,
   // write channel
   input  logic                     wr_cmd_valid,
   input  logic [opcode_w-1:0]      wr_cmd_opcode,
   input  logic [ea_w-1:0]          wr_cmd_ea,
   input  logic [afutag_w-1:0]      wr_cmd_afutag,
   input  logic [dl_w-1:0]          wr_cmd_dl,
   input  logic [pl_w-1:0]          wr_cmd_pl,
   input  logic [2*half_data_w-1:0] wr_cdata_bus,
   output logic                     wr_cmd_ready,
   // read channel
   input  logic                     rd_cmd_valid,
   input  logic [opcode_w-1:0]      rd_cmd_opcode,
   input  logic [ea_w-1:0]          rd_cmd_ea,
   input  logic [afutag_w-1:0]      rd_cmd_afutag,
   input  logic [dl_w-1:0]          rd_cmd_dl,
   input  logic [pl_w-1:0]          rd_cmd_pl,
   output logic                     rd_cmd_ready,
   // TLX command port
   output logic                     cmd_valid,
   output logic [opcode_w-1:0]      cmd_opcode,
   output logic [ea_w-1:0]          cmd_ea,
   output logic [afutag_w-1:0]      cmd_afutag,
   output logic [dl_w-1:0]          cmd_dl,
   output logic [pl_w-1:0]          cmd_pl,
   output logic                     cdata_valid,
   output logic [half_data_w-1:0]   cdata_bus,
   input  logic                     cmd_credit,
   input  logic                     data_credit,
   input  logic [cmd_credit_w-1:0]  cmd_initial_credit,
   input  logic [data_credit_w-1:0] data_initial_credit,
   // bit 1 read queue, bit 0 write queue
   output logic [1:0]               fir_fifo_overflow
);

   localparam int wr_entry_w = cmd_info_w + 2 * half_data_w;
   localparam int dl_lsb     = opcode_w + ea_w + afutag_w;

   logic [wr_entry_w-1:0]  wr_head;
   logic [cmd_info_w-1:0]  rd_head;
   logic [cmd_info_w-1:0]  cmd_info;
   logic [half_data_w-1:0] odd_data_q;
   logic                   wr_empty;
   logic                   rd_empty;
   logic                   wr_pop;
   logic                   rd_pop;
   logic                   issue_ok;
   logic                   sel_write;
   logic                   sel_high;

   // ---------------------------------------------------------------------
   // channel queues, write entries carry both data halves
   // ---------------------------------------------------------------------
   cmd_fifo #(.data_w(wr_entry_w), .addr_w(fifo_addr_w)) u_wr_fifo (
      .clk_tlx    (clk_tlx),
      .rst_n      (rst_n),
      .push       (wr_cmd_valid),
      .push_data  ({wr_cdata_bus, wr_cmd_pl, wr_cmd_dl, wr_cmd_afutag,
                    wr_cmd_ea, wr_cmd_opcode}),
      .pop        (wr_pop),
      .head       (wr_head),
      .empty      (wr_empty),
      .half_ready (wr_cmd_ready),
      .overflow   (fir_fifo_overflow[0])
   );

   cmd_fifo #(.data_w(cmd_info_w), .addr_w(fifo_addr_w)) u_rd_fifo (
      .clk_tlx    (clk_tlx),
      .rst_n      (rst_n),
      .push       (rd_cmd_valid),
      .push_data  ({rd_cmd_pl, rd_cmd_dl, rd_cmd_afutag, rd_cmd_ea, rd_cmd_opcode}),
      .pop        (rd_pop),
      .head       (rd_head),
      .empty      (rd_empty),
      .half_ready (rd_cmd_ready),
      .overflow   (fir_fifo_overflow[1])
   );

   credit_counter u_credit (
      .clk_tlx             (clk_tlx),
      .rst_n               (rst_n),
      .cmd_initial_credit  (cmd_initial_credit),
      .data_initial_credit (data_initial_credit),
      .cmd_credit          (cmd_credit),
      .data_credit         (data_credit),
      .cmd_spent           (cmd_valid),
      .data_spent          (cdata_valid),
      .issue_ok            (issue_ok)
   );

   cmd_issue_fsm u_fsm (
      .clk_tlx     (clk_tlx),
      .rst_n       (rst_n),
      .wr_empty    (wr_empty),
      .rd_empty    (rd_empty),
      .wr_dl       (wr_head[dl_lsb +: dl_w]),
      .issue_ok    (issue_ok),
      .wr_pop      (wr_pop),
      .rd_pop      (rd_pop),
      .cmd_valid   (cmd_valid),
      .cdata_valid (cdata_valid),
      .sel_write   (sel_write),
      .sel_high    (sel_high)
   );

   // ---------------------------------------------------------------------
   // output port
   // ---------------------------------------------------------------------
   assign cmd_info = sel_write ? wr_head[cmd_info_w-1:0] : rd_head;
   assign {cmd_pl, cmd_dl, cmd_afutag, cmd_ea, cmd_opcode} = cmd_info;

   // entry leaves the queue with the command, so hold its upper half here
   always_ff @(posedge clk_tlx)
   begin
      if (wr_pop)
         odd_data_q <= wr_head[cmd_info_w+half_data_w +: half_data_w];
   end

   assign cdata_bus = sel_high ? odd_data_q : wr_head[cmd_info_w +: half_data_w];

endmodule

// File: verification/tlx_cmd_issue_assertions.sv
// protocol and credit checks, bound into the command issue top level
// keeps its own count of TLX credit from the initial values and return pulses

module tlx_cmd_issue_assertions
   import tlx_cmd_pkg::*;
(
   input logic                     clk_tlx,
   input logic                     rst_n,
   input logic                     cmd_valid,
   input logic                     cdata_valid,
   input logic [dl_w-1:0]          cmd_dl,
   input logic                     sel_write,
   input logic                     wr_pop,
   input logic                     rd_pop,
   input logic                     wr_empty,
   input logic                     rd_empty,
   input logic                     cmd_credit,
   input logic                     data_credit,
   input logic [cmd_credit_w-1:0]  cmd_initial_credit,
   input logic [data_credit_w-1:0] data_initial_credit
);

   int   fail_count = 0;
   int   cmd_left;
   int   data_left;
   logic loaded;
   logic served_write;

   // credit model: load once after reset, then returns minus spends
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         loaded    <= 1'b0;
         cmd_left  <= 0;
         data_left <= 0;
      end
      else
      begin
         loaded    <= 1'b1;
         cmd_left  <= loaded ? cmd_left + cmd_credit - cmd_valid : int'(cmd_initial_credit);
         data_left <= loaded ? data_left + data_credit - cdata_valid : int'(data_initial_credit);
      end
   end

   // channel of the last issued command, read after reset
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
         served_write <= 1'b0;
      else if (cmd_valid)
         served_write <= wr_pop;
   end

   a_credit: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      cmd_valid |-> (cmd_left > 0) && (data_left >= min_data_credit))
      else
      begin
         $error("command issued without enough credit");
         fail_count++;
      end

   // a 128B write owns the next cycle for its high beat
   a_high_beat: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      (cmd_valid && sel_write && (cmd_dl == dl_128b)) |=> cdata_valid)
      else
      begin
         $error("high data beat missing after 128B write");
         fail_count++;
      end

   a_odd_quiet: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      (cmd_valid && sel_write && (cmd_dl == dl_128b)) |=> !cmd_valid)
      else
      begin
         $error("command issued during the high data beat");
         fail_count++;
      end

   // with both queues waiting, exactly one pops and it is the one not served last
   a_alternate: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      (cmd_valid && !wr_empty && !rd_empty) |->
         $onehot({wr_pop, rd_pop}) && (wr_pop != served_write))
      else
      begin
         $error("arbitration did not pop the queue served less recently");
         fail_count++;
      end

endmodule

bind tlx_cmd_issue tlx_cmd_issue_assertions u_assertions (.*);

// File: verification/tb_tlx_cmd_issue.sv
// testbench for the command issue stage
// pushes read and write commands, gates issue with credits and checks every
// issued command and data beat against reference queues

module tb_tlx_cmd_issue
   import tlx_cmd_pkg::*;
();

   localparam int half_w     = 512;
   localparam int wait_limit = 100;
   localparam int dl_lsb     = opcode_w + ea_w + afutag_w;
   localparam int tag_msb    = dl_lsb - 1;

   logic                     clk_tlx = 1'b0;
   logic                     rst_n;
   logic                     wr_cmd_valid;
   logic [opcode_w-1:0]      wr_cmd_opcode;
   logic [ea_w-1:0]          wr_cmd_ea;
   logic [afutag_w-1:0]      wr_cmd_afutag;
   logic [dl_w-1:0]          wr_cmd_dl;
   logic [pl_w-1:0]          wr_cmd_pl;
   logic [2*half_w-1:0]      wr_cdata_bus;
   logic                     rd_cmd_valid;
   logic [opcode_w-1:0]      rd_cmd_opcode;
   logic [ea_w-1:0]          rd_cmd_ea;
   logic [afutag_w-1:0]      rd_cmd_afutag;
   logic [dl_w-1:0]          rd_cmd_dl;
   logic [pl_w-1:0]          rd_cmd_pl;
   logic                     cmd_credit;
   logic                     data_credit;
   logic [cmd_credit_w-1:0]  cmd_initial_credit;
   logic [data_credit_w-1:0] data_initial_credit;
   logic                     wr_cmd_ready;
   logic                     rd_cmd_ready;
   logic                     cmd_valid;
   logic [opcode_w-1:0]      cmd_opcode;
   logic [ea_w-1:0]          cmd_ea;
   logic [afutag_w-1:0]      cmd_afutag;
   logic [dl_w-1:0]          cmd_dl;
   logic [pl_w-1:0]          cmd_pl;
   logic                     cdata_valid;
   logic [half_w-1:0]        cdata_bus;
   logic [1:0]               fir_fifo_overflow;

   integer                seed;
   int                    err_count;
   int                    test_errors;
   int                    test_num;
   int                    assert_base;
   int                    issue_count;
   int                    i;
   logic                  expect_high;
   logic [cmd_info_w-1:0] exp_info;
   logic [2*half_w-1:0]   exp_data;
   logic [cmd_info_w-1:0] wr_info_q[$];
   logic [2*half_w-1:0]   wr_data_q[$];
   logic [cmd_info_w-1:0] rd_info_q[$];
   logic                  issued_ch[$];

   tlx_cmd_issue tlx_cmd_issue_inst (.*);

   // 100 unit period
   always #50 clk_tlx = ~clk_tlx;

   // ---------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------
   task automatic report_problem(input string msg);
      begin
         $display("%s", msg);
         err_count++;
         test_errors++;
      end
   endtask

   task automatic check_value(input string name, input logic [511:0] got,
                              input logic [511:0] exp);
      begin
         if (got !== exp)
            report_problem($sformatf("Error: %s expected %0h got %0h", name, exp, got));
      end
   endtask

   // strobes last one cycle, inputs change 10 units after the edge
   task automatic next_cycle();
      begin
         @(posedge clk_tlx);
         #10;
         wr_cmd_valid = 1'b0;
         rd_cmd_valid = 1'b0;
         cmd_credit   = 1'b0;
         data_credit  = 1'b0;
      end
   endtask

   task automatic reset_dut(input logic [cmd_credit_w-1:0] cmd_init,
                            input logic [data_credit_w-1:0] data_init);
      begin
         rst_n        = 1'b0;
         wr_cmd_valid = 1'b0;
         rd_cmd_valid = 1'b0;
         cmd_credit   = 1'b0;
         data_credit  = 1'b0;
         wr_cdata_bus = '0;
         {wr_cmd_pl, wr_cmd_dl, wr_cmd_afutag, wr_cmd_ea, wr_cmd_opcode} = {cmd_info_w{1'b0}};
         {rd_cmd_pl, rd_cmd_dl, rd_cmd_afutag, rd_cmd_ea, rd_cmd_opcode} = {cmd_info_w{1'b0}};
         cmd_initial_credit  = cmd_init;
         data_initial_credit = data_init;
         wr_info_q.delete();
         wr_data_q.delete();
         rd_info_q.delete();
         issued_ch.delete();
         expect_high = 1'b0;
         issue_count = 0;
         repeat (8) @(posedge clk_tlx);
         #10;
         rst_n = 1'b1;
      end
   endtask

   // random fields, tag msb marks the channel so the monitor can tell them apart
   task automatic load_cmd(input logic to_write, input logic [dl_w-1:0] dl);
      logic [127:0]          r;
      logic [cmd_info_w-1:0] info;
      logic [2*half_w-1:0]   data;
      int                    k;
      begin
         r = {$random(seed), $random(seed), $random(seed), $random(seed)};
         info = r[cmd_info_w-1:0];
         info[tag_msb] = to_write;
         info[dl_lsb +: dl_w] = dl;
         if (to_write)
         begin
            for (k = 0; k < 2 * half_w / 32; k++)
               data[k*32 +: 32] = $random(seed);
            {wr_cmd_pl, wr_cmd_dl, wr_cmd_afutag, wr_cmd_ea, wr_cmd_opcode} = info;
            wr_cdata_bus = data;
            wr_cmd_valid = 1'b1;
            wr_info_q.push_back(info);
            wr_data_q.push_back(data);
         end
         else
         begin
            {rd_cmd_pl, rd_cmd_dl, rd_cmd_afutag, rd_cmd_ea, rd_cmd_opcode} = info;
            rd_cmd_valid = 1'b1;
            rd_info_q.push_back(info);
         end
      end
   endtask

   task automatic wait_issues(input int n);
      int cycles;
      begin
         cycles = 0;
         while ((issue_count < n) && (cycles < wait_limit))
         begin
            next_cycle();
            cycles++;
         end
         if (issue_count < n)
            report_problem($sformatf("timeout: only %0d of %0d commands issued",
                                     issue_count, n));
      end
   endtask

   // nothing more may issue once the credit is used up
   task automatic check_count(input int exp);
      begin
         repeat (8) next_cycle();
         if (issue_count != exp)
            report_problem($sformatf("issue should stop after %0d commands but %0d issued",
                                     exp, issue_count));
      end
   endtask

   task automatic end_test(input string name);
      int fails;
      begin
         fails = test_errors + tlx_cmd_issue_inst.u_assertions.fail_count - assert_base;
         $display("test %0d %s: %0d errors", test_num, name, fails);
         test_num++;
         test_errors = 0;
         assert_base = tlx_cmd_issue_inst.u_assertions.fail_count;
      end
   endtask

   // ---------------------------------------------------------------------
   // monitor, sampled mid-cycle where the outputs are settled
   // ---------------------------------------------------------------------
   always @(negedge clk_tlx)
   begin
      if (rst_n && expect_high)
      begin
         expect_high = 1'b0;
         check_value("cdata_valid", cdata_valid, 1'b1);
         check_value("cdata_bus", cdata_bus, exp_data[2*half_w-1:half_w]);
      end
      else if (rst_n && cmd_valid)
      begin
         if ((cmd_afutag[afutag_w-1] ? wr_info_q.size() : rd_info_q.size()) == 0)
            report_problem("command issued with nothing queued on its channel");
         else
         begin
            if (cmd_afutag[afutag_w-1])
            begin
               exp_info = wr_info_q.pop_front();
               exp_data = wr_data_q.pop_front();
               check_value("cdata_valid", cdata_valid, 1'b1);
               check_value("cdata_bus", cdata_bus, exp_data[half_w-1:0]);
               expect_high = (exp_info[dl_lsb +: dl_w] == dl_128b);
            end
            else
            begin
               exp_info = rd_info_q.pop_front();
               check_value("cdata_valid", cdata_valid, 1'b0);
            end
            check_value("cmd_opcode", cmd_opcode, exp_info[0 +: opcode_w]);
            check_value("cmd_ea", cmd_ea, exp_info[opcode_w +: ea_w]);
            check_value("cmd_afutag", cmd_afutag, exp_info[opcode_w+ea_w +: afutag_w]);
            check_value("cmd_dl", cmd_dl, exp_info[dl_lsb +: dl_w]);
            check_value("cmd_pl", cmd_pl, exp_info[dl_lsb+dl_w +: pl_w]);
         end
         issued_ch.push_back(cmd_afutag[afutag_w-1]);
         issue_count++;
      end
   end

   // ---------------------------------------------------------------------
   // tests
   // ---------------------------------------------------------------------
   initial
   begin
      seed        = 32'he07f;
      err_count   = 0;
      test_errors = 0;
      test_num    = 1;
      assert_base = 0;
      reset_dut(4'd15, 6'd63);

      check_value("cmd_valid", cmd_valid, 1'b0);
      check_value("cdata_valid", cdata_valid, 1'b0);
      check_value("fir_fifo_overflow", fir_fifo_overflow, 2'b00);
      check_value("wr_cmd_ready", wr_cmd_ready, 1'b1);
      check_value("rd_cmd_ready", rd_cmd_ready, 1'b1);
      end_test("reset values");

      load_cmd(1'b1, dl_64b);
      wait_issues(1);
      repeat (2) next_cycle();
      end_test("64B write");

      load_cmd(1'b1, dl_128b);
      wait_issues(2);
      repeat (2) next_cycle();
      end_test("128B write");

      // hold issue off until both queues are loaded, then release one credit per cycle
      reset_dut(4'd0, 6'd63);
      for (i = 0; i < 4; i++)
      begin
         next_cycle();
         load_cmd(1'b1, (i % 2 == 1) ? dl_128b : dl_64b);
         load_cmd(1'b0, dl_64b);
      end
      for (i = 0; i < 8; i++)
      begin
         next_cycle();
         cmd_credit = 1'b1;
      end
      wait_issues(8);
      repeat (2) next_cycle();
      for (i = 0; i < issued_ch.size(); i++)
         if (issued_ch[i] != (i % 2 == 0))
            report_problem($sformatf("channel order broken at command %0d", i));
      end_test("alternation");

      reset_dut(4'd3, 6'd63);
      for (i = 0; i < 5; i++)
      begin
         next_cycle();
         load_cmd(1'b0, dl_64b);
      end
      wait_issues(3);
      check_count(3);
      cmd_credit = 1'b1;
      wait_issues(4);
      check_count(4);
      reset_dut(4'd15, 6'd3);
      for (i = 0; i < 3; i++)
      begin
         next_cycle();
         load_cmd(1'b1, dl_64b);
      end
      wait_issues(2);
      check_count(2);
      data_credit = 1'b1;
      wait_issues(3);
      check_count(3);
      end_test("credit limits");

      reset_dut(4'd0, 6'd0);
      for (i = 1; i <= 17; i++)
      begin
         load_cmd(1'b1, dl_64b);
         next_cycle();
         if (i == 7)
            check_value("wr_cmd_ready", wr_cmd_ready, 1'b1);
         if (i == 8)
            check_value("wr_cmd_ready", wr_cmd_ready, 1'b0);
         if (i == 16)
            check_value("fir_fifo_overflow", fir_fifo_overflow, 2'b00);
      end
      load_cmd(1'b0, dl_64b);
      next_cycle();
      check_value("fir_fifo_overflow", fir_fifo_overflow, 2'b01);
      check_value("rd_cmd_ready", rd_cmd_ready, 1'b1);
      end_test("queue fill and overflow");

      $display("%0d tests, %0d check errors, %0d assertion failures", test_num - 1,
               err_count, tlx_cmd_issue_inst.u_assertions.fail_count);
      if ((err_count == 0) && (tlx_cmd_issue_inst.u_assertions.fail_count == 0))
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: src.f
design/tlx_cmd_pkg.sv
design/cmd_fifo.sv
design/credit_counter.sv
design/cmd_issue_fsm.sv
design/tlx_cmd_issue.sv
verification/tlx_cmd_issue_assertions.sv
verification/tb_tlx_cmd_issue.sv
